/* design/tile_pkg.sv */
/*
 * Shared types and instruction layout for the single-issue compute tile.
 * Branch offsets are in words, relative to the pc of the bnz itself.
 * Undefined opcode encodings decode as a no-op.
 */

package tile_pkg;

   // Data and instruction word
   typedef logic [31:0] word_t;

   // Register index, r0 hardwired to zero
   typedef logic [4:0] reg_idx_t;

   // Instruction field positions
   localparam int op_msb  = 31;
   localparam int op_lsb  = 26;
   localparam int rd_msb  = 25;
   localparam int rd_lsb  = 21;
   localparam int ra_msb  = 20;
   localparam int ra_lsb  = 16;
   localparam int rb_msb  = 15;
   localparam int rb_lsb  = 11;
   localparam int imm_msb = 15;
   localparam int imm_lsb = 0;

   // Opcodes, held in bits 31..26
   typedef enum logic [5:0] {
      op_nop   = 6'h00,
      op_add   = 6'h01,
      op_sub   = 6'h02,
      op_and   = 6'h03,
      op_or    = 6'h04,
      op_xor   = 6'h05,
      op_sll   = 6'h06,
      op_addi  = 6'h08,
      op_movhi = 6'h09,
      op_bnz   = 6'h0a,
      op_halt  = 6'h3f
   } op_t;

   // Core sequencing states
   typedef enum logic [2:0] {
      st_idle,
      st_fetch,
      st_exec,
      st_write,
      st_halted
   } core_state_t;

endpackage

/* design/insn_decode.sv */
/*
 * Combinational instruction decode.
 * Unknown opcodes come out as op_nop; movhi places imm in the upper half,
 * all other forms sign-extend it.
 */

module insn_decode (
   input  tile_pkg::word_t    insn,
   output tile_pkg::op_t      op,
   output tile_pkg::reg_idx_t rd,
   output tile_pkg::reg_idx_t ra,
   output tile_pkg::reg_idx_t rb,
   output tile_pkg::word_t    imm,
   output logic               writes_rd,
   output logic               is_branch,
   output logic               is_halt
);

   logic [5:0]  op_field;
   logic [15:0] imm_field;
   logic        writes_any;

   assign op_field  = insn[tile_pkg::op_msb:tile_pkg::op_lsb];
   assign imm_field = insn[tile_pkg::imm_msb:tile_pkg::imm_lsb];

   assign rd = insn[tile_pkg::rd_msb:tile_pkg::rd_lsb];
   assign ra = insn[tile_pkg::ra_msb:tile_pkg::ra_lsb];
   assign rb = insn[tile_pkg::rb_msb:tile_pkg::rb_lsb];

   // Known encodings pass through, anything else is a no-op
   always_comb begin
      case (op_field)
         tile_pkg::op_add,
         tile_pkg::op_sub,
         tile_pkg::op_and,
         tile_pkg::op_or,
         tile_pkg::op_xor,
         tile_pkg::op_sll,
         tile_pkg::op_addi,
         tile_pkg::op_movhi,
         tile_pkg::op_bnz,
         tile_pkg::op_halt: op = tile_pkg::op_t'(op_field);
         default:           op = tile_pkg::op_nop;
      endcase
   end

   // Immediate extension
   always_comb begin
      if (op == tile_pkg::op_movhi) begin
         imm = {imm_field, 16'h0000};
      end else begin
         imm = {{16{imm_field[15]}}, imm_field};
      end
   end

   // Ops that produce a register result
   always_comb begin
      case (op)
         tile_pkg::op_add,
         tile_pkg::op_sub,
         tile_pkg::op_and,
         tile_pkg::op_or,
         tile_pkg::op_xor,
         tile_pkg::op_sll,
         tile_pkg::op_addi,
         tile_pkg::op_movhi: writes_any = 1'b1;
         default:            writes_any = 1'b0;
      endcase
   end

   // Writes to r0 are dropped here
   assign writes_rd = writes_any && (rd != '0);
   assign is_branch = (op == tile_pkg::op_bnz);
   assign is_halt   = (op == tile_pkg::op_halt);

endmodule

/* design/alu_execute.sv */
/*
 * Combinational ALU and branch condition.
 * All arithmetic wraps at 32 bits; sll uses only b[4:0].
 */

module alu_execute (
   input  tile_pkg::op_t   op,
   input  tile_pkg::word_t a,
   input  tile_pkg::word_t b,
   input  tile_pkg::word_t imm,
   output tile_pkg::word_t result,
   output logic            take_branch
);

   tile_pkg::word_t opnd_b;
   tile_pkg::word_t sum;

   // Second operand, register or immediate form
   assign opnd_b = (op == tile_pkg::op_addi) ? imm : b;

   // Shared adder for add and addi
   assign sum = a + opnd_b;

   always_comb begin
      case (op)
         tile_pkg::op_add,
         tile_pkg::op_addi: begin
            result = sum;
         end
         tile_pkg::op_sub: begin
            result = a - opnd_b;
         end
         tile_pkg::op_and: begin
            result = a & opnd_b;
         end
         tile_pkg::op_or: begin
            result = a | opnd_b;
         end
         tile_pkg::op_xor: begin
            result = a ^ opnd_b;
         end
         tile_pkg::op_sll: begin
            result = a << opnd_b[4:0];
         end
         tile_pkg::op_movhi: begin
            // Decode already shifted the immediate up
            result = imm;
         end
         default: begin
            // bnz, nop, halt write nothing
            result = '0;
         end
      endcase
   end

   // Branch when ra is nonzero
   assign take_branch = (op == tile_pkg::op_bnz) && (a != '0);

endmodule

/* design/reg_writeback.sv */
/*
 * Register file and execution trace registers.
 * Reads are combinational; trace fields show zero reg and data when the
 * retired instruction wrote nothing.
 */

module reg_writeback (
   input  logic               clk,
   input  logic               reset,
   input  logic               wr_en,
   input  tile_pkg::reg_idx_t wr_idx,
   input  tile_pkg::word_t    wr_data,
   input  tile_pkg::reg_idx_t rd_idx_a,
   input  tile_pkg::reg_idx_t rd_idx_b,
   output tile_pkg::word_t    rd_data_a,
   output tile_pkg::word_t    rd_data_b,
   input  logic               retire,
   input  tile_pkg::word_t    retire_pc,
   input  tile_pkg::word_t    retire_insn,
   output logic               trace_valid,
   output tile_pkg::word_t    trace_pc,
   output tile_pkg::word_t    trace_insn,
   output logic               trace_wben,
   output tile_pkg::reg_idx_t trace_wbreg,
   output tile_pkg::word_t    trace_wbdata
);

   // r1..r31, r0 is not stored
   tile_pkg::word_t regs [1:31];
   logic            do_write;

   assign do_write = retire && wr_en && (wr_idx != '0);

   assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
   assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
         trace_valid <= 1'b0;
         trace_wben  <= 1'b0;
      end else begin
         trace_valid <= retire;
         if (retire) begin
            trace_wben <= do_write;
         end
         if (do_write) begin
            regs[wr_idx] <= wr_data;
         end
      end
   end

   // Trace payload, same edge as the register write
   always_ff @(posedge clk) begin
      if (retire) begin
         trace_pc     <= retire_pc;
         trace_insn   <= retire_insn;
         trace_wbreg  <= do_write ? wr_idx : '0;
         trace_wbdata <= do_write ? wr_data : '0;
      end
   end

endmodule

/* design/compute_core.sv */
/*
 * Non-pipelined core: fetch, exec, write per instruction, one in flight.
 * imem_addr is the pc for the next cycle, so the synchronous memory has the
 * word ready during st_fetch. The pc wraps at 2**imem_addr_w words.
 */

module compute_core #(
   parameter int imem_addr_w = 8
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   output logic [imem_addr_w-1:0] imem_addr,
   input  tile_pkg::word_t        imem_data,
   output logic                   idle,
   output logic                   halted,
   output logic                   trace_valid,
   output tile_pkg::word_t        trace_pc,
   output tile_pkg::word_t        trace_insn,
   output logic                   trace_wben,
   output tile_pkg::reg_idx_t     trace_wbreg,
   output tile_pkg::word_t        trace_wbdata
);

   tile_pkg::core_state_t  state;
   logic [imem_addr_w-1:0] pc;
   logic [imem_addr_w-1:0] pc_next;
   tile_pkg::word_t        insn_q;
   tile_pkg::word_t        result_q;
   logic                   take_q;

   tile_pkg::op_t      op;
   tile_pkg::reg_idx_t rd;
   tile_pkg::reg_idx_t ra;
   tile_pkg::reg_idx_t rb;
   tile_pkg::word_t    imm;
   logic               writes_rd;
   logic               is_branch;
   logic               is_halt;
   tile_pkg::word_t    data_a;
   tile_pkg::word_t    data_b;
   tile_pkg::word_t    result;
   logic               take_branch;

   insn_decode u_decode (
      .insn      (insn_q),
      .op        (op),
      .rd        (rd),
      .ra        (ra),
      .rb        (rb),
      .imm       (imm),
      .writes_rd (writes_rd),
      .is_branch (is_branch),
      .is_halt   (is_halt)
   );

   alu_execute u_execute (
      .op          (op),
      .a           (data_a),
      .b           (data_b),
      .imm         (imm),
      .result      (result),
      .take_branch (take_branch)
   );

   reg_writeback u_writeback (
      .clk          (clk),
      .reset        (reset),
      .wr_en        (writes_rd),
      .wr_idx       (rd),
      .wr_data      (result_q),
      .rd_idx_a     (ra),
      .rd_idx_b     (rb),
      .rd_data_a    (data_a),
      .rd_data_b    (data_b),
      .retire       (state == tile_pkg::st_write),
      .retire_pc    (tile_pkg::word_t'({pc, 2'b00})),
      .retire_insn  (insn_q),
      .trace_valid  (trace_valid),
      .trace_pc     (trace_pc),
      .trace_insn   (trace_insn),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata)
   );

   // Next pc; halt leaves it on the halt word
   always_comb begin
      pc_next = pc;
      case (state)
         tile_pkg::st_idle,
         tile_pkg::st_halted: begin
            if (start) begin
               pc_next = '0;
            end
         end
         tile_pkg::st_write: begin
            if (is_branch && take_q) begin
               pc_next = pc + imm[imem_addr_w-1:0];
            end else if (!is_halt) begin
               pc_next = pc + 1'b1;
            end
         end
         default: begin
            pc_next = pc;
         end
      endcase
   end

   assign imem_addr = pc_next;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= tile_pkg::st_idle;
         pc    <= '0;
      end else begin
         pc <= pc_next;
         case (state)
            tile_pkg::st_idle,
            tile_pkg::st_halted: begin
               if (start) begin
                  state <= tile_pkg::st_fetch;
               end
            end
            tile_pkg::st_fetch: begin
               state <= tile_pkg::st_exec;
            end
            tile_pkg::st_exec: begin
               state <= tile_pkg::st_write;
            end
            tile_pkg::st_write: begin
               state <= is_halt ? tile_pkg::st_halted : tile_pkg::st_fetch;
            end
            default: begin
               state <= tile_pkg::st_idle;
            end
         endcase
      end
   end

   // Instruction latch and execute result
   always_ff @(posedge clk) begin
      if (state == tile_pkg::st_fetch) begin
         insn_q <= imem_data;
      end
      if (state == tile_pkg::st_exec) begin
         result_q <= result;
         take_q   <= take_branch;
      end
   end

   assign idle   = (state == tile_pkg::st_idle);
   assign halted = (state == tile_pkg::st_halted);

endmodule

/* design/compute_tile.sv */
/*
 * Single compute tile: core plus 2**imem_addr_w word instruction memory.
 * Host loads are ignored unless the core is idle or halted.
 */

module compute_tile #(
   parameter int imem_addr_w = 8
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  logic                   load_we,
   input  logic [imem_addr_w-1:0] load_addr,
   input  tile_pkg::word_t        load_data,
   output logic                   halted,
   output logic                   trace_valid,
   output tile_pkg::word_t        trace_pc,
   output tile_pkg::word_t        trace_insn,
   output logic                   trace_wben,
   output tile_pkg::reg_idx_t     trace_wbreg,
   output tile_pkg::word_t        trace_wbdata
);

   tile_pkg::word_t        imem [0:(2**imem_addr_w)-1];
   logic [imem_addr_w-1:0] imem_addr;
   tile_pkg::word_t        imem_data;
   logic                   core_idle;

   // Write port for the host, synchronous read for the core
   always_ff @(posedge clk) begin
      if (load_we && (core_idle || halted)) begin
         imem[load_addr] <= load_data;
      end
      imem_data <= imem[imem_addr];
   end

   compute_core #(
      .imem_addr_w (imem_addr_w)
   ) u_core (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .imem_addr    (imem_addr),
      .imem_data    (imem_data),
      .idle         (core_idle),
      .halted       (halted),
      .trace_valid  (trace_valid),
      .trace_pc     (trace_pc),
      .trace_insn   (trace_insn),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata)
   );

endmodule

/* bench/trace_assert.sv */
/*
 * Trace and state protocol checks, bound into every compute_core.
 * Relies on the core's internal state signal being named state.
 */

module trace_assert (
   input logic                  clk,
   input logic                  reset,
   input tile_pkg::core_state_t state,
   input logic                  trace_valid,
   input logic                  trace_wben,
   input tile_pkg::reg_idx_t    trace_wbreg
);

   timeunit 1ns;
   timeprecision 1ps;

   // One pulse per retired instruction
   a_single_pulse: assert property (@(posedge clk) disable iff (reset)
      trace_valid |=> !trace_valid)
      else $error("trace_valid held high for two cycles");

   // r0 is never reported as written
   a_wbreg_nonzero: assert property (@(posedge clk) disable iff (reset)
      trace_wben |-> (trace_wbreg != '0))
      else $error("trace_wben high with trace_wbreg zero");

   a_quiet_idle: assert property (@(posedge clk) disable iff (reset)
      (state == tile_pkg::st_idle) |-> !trace_valid)
      else $error("trace pulse while idle");

   // Halt's own pulse is allowed in the first halted cycle only
   a_quiet_halted: assert property (@(posedge clk) disable iff (reset)
      (state == tile_pkg::st_halted && $past(state) == tile_pkg::st_halted)
      |-> !trace_valid)
      else $error("trace pulse while halted");

endmodule

bind compute_core trace_assert u_trace_assert (
   .clk         (clk),
   .reset       (reset),
   .state       (state),
   .trace_valid (trace_valid),
   .trace_wben  (trace_wben),
   .trace_wbreg (trace_wbreg)
);

/* bench/tb_compute_tile.sv */
/*
 * Table-driven testbench for compute_tile. Expected trace values come from
 * an ISA model run while the table is built, so rows are in retirement order.
 * Registers persist across programs, in the DUT and in the model.
 */

module tb_compute_tile;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int imem_addr_w = 8;
   localparam int depth       = 1 << imem_addr_w;

   logic                   clk;
   logic                   reset;
   logic                   start;
   logic                   load_we;
   logic [imem_addr_w-1:0] load_addr;
   tile_pkg::word_t        load_data;
   logic                   halted;
   logic                   trace_valid;
   tile_pkg::word_t        trace_pc;
   tile_pkg::word_t        trace_insn;
   logic                   trace_wben;
   tile_pkg::reg_idx_t     trace_wbreg;
   tile_pkg::word_t        trace_wbdata;

   // Stimulus table, one row per retired instruction
   string                  row_name   [$];
   int                     row_prog   [$];
   int                     row_pc     [$];
   tile_pkg::word_t        row_insn   [$];
   logic                   row_wben   [$];
   tile_pkg::reg_idx_t     row_wbreg  [$];
   tile_pkg::word_t        row_wbdata [$];

   // Reference register file and pc
   tile_pkg::word_t        model_regs [0:31];
   int                     model_pc;
   int                     n_progs;
   int                     errors;
   int                     checks;
   int                     cycles;
   int                     limit;

   compute_tile #(
      .imem_addr_w (imem_addr_w)
   ) uut (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .load_we      (load_we),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .halted       (halted),
      .trace_valid  (trace_valid),
      .trace_pc     (trace_pc),
      .trace_insn   (trace_insn),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata)
   );

   always #50 clk = ~clk;

   // Run limit, armed once the table is built
   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles >= limit) begin
         $display("ERROR: timeout, no trace pulse after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic check_word(input string name, input tile_pkg::word_t exp,
                             input tile_pkg::word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_reg(input string name, input tile_pkg::reg_idx_t exp,
                            input tile_pkg::reg_idx_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // Encodings: op 31..26, rd 25..21, ra 20..16, rb 15..11, imm 15..0
   function automatic tile_pkg::word_t r_form(input tile_pkg::op_t op,
      input tile_pkg::reg_idx_t rd, input tile_pkg::reg_idx_t ra,
      input tile_pkg::reg_idx_t rb);
      return {op, rd, ra, rb, 11'h000};
   endfunction

   function automatic tile_pkg::word_t i_form(input tile_pkg::op_t op,
      input tile_pkg::reg_idx_t rd, input tile_pkg::reg_idx_t ra,
      input logic [15:0] imm);
      return {op, rd, ra, imm};
   endfunction

   task automatic begin_program();
      n_progs++;
      model_pc = 0;
   endtask

   // Runs one instruction through the model and records its trace row
   task automatic add_row(input string name, input tile_pkg::word_t insn);
      logic [5:0]         opf;
      tile_pkg::reg_idx_t rd;
      tile_pkg::word_t    a;
      tile_pkg::word_t    b;
      tile_pkg::word_t    sx;
      tile_pkg::word_t    val;
      logic               wr;
      int                 next_pc;
      opf     = insn[31:26];
      rd      = insn[25:21];
      a       = model_regs[insn[20:16]];
      b       = model_regs[insn[15:11]];
      sx      = {{16{insn[15]}}, insn[15:0]};
      wr      = 1'b1;
      val     = '0;
      next_pc = (model_pc + 1) % depth;
      case (opf)
         tile_pkg::op_add:   val = a + b;
         tile_pkg::op_sub:   val = a - b;
         tile_pkg::op_and:   val = a & b;
         tile_pkg::op_or:    val = a | b;
         tile_pkg::op_xor:   val = a ^ b;
         tile_pkg::op_sll:   val = a << b[4:0];
         tile_pkg::op_addi:  val = a + sx;
         tile_pkg::op_movhi: val = {insn[15:0], 16'h0000};
         tile_pkg::op_bnz: begin
            wr = 1'b0;
            // Offset in words from the bnz itself
            if (a != '0) begin
               next_pc = (model_pc + $signed(sx)) & (depth - 1);
            end
         end
         default:            wr = 1'b0;
      endcase
      wr = wr && (rd != '0);
      row_name.push_back(name);
      row_prog.push_back(n_progs - 1);
      row_pc.push_back(model_pc);
      row_insn.push_back(insn);
      row_wben.push_back(wr);
      row_wbreg.push_back(wr ? rd : 5'd0);
      row_wbdata.push_back(wr ? val : 32'h0);
      if (wr) begin
         model_regs[rd] = val;
      end
      model_pc = next_pc;
   endtask

   task automatic load_word(input int addr, input tile_pkg::word_t data);
      @(negedge clk);
      load_we   = 1'b1;
      load_addr = addr[imem_addr_w-1:0];
      load_data = data;
   endtask

   // Counts falling edges until the next trace pulse, drops start on the first
   task automatic wait_pulse(output int gap);
      gap = 0;
      do begin
         @(negedge clk);
         start = 1'b0;
         gap++;
      end while (trace_valid !== 1'b1);
   endtask

   task automatic check_row(input int r, input int exp_gap, input int gap);
      string name;
      logic  is_halt;
      name    = row_name[r];
      is_halt = (row_insn[r][31:26] == tile_pkg::op_halt);
      check_word({name, " gap"}, tile_pkg::word_t'(exp_gap), tile_pkg::word_t'(gap));
      check_word({name, " pc"}, tile_pkg::word_t'(row_pc[r] * 4), trace_pc);
      check_word({name, " insn"}, row_insn[r], trace_insn);
      check_bit({name, " wben"}, row_wben[r], trace_wben);
      if (row_wben[r]) begin
         check_reg({name, " wbreg"}, row_wbreg[r], trace_wbreg);
         check_word({name, " wbdata"}, row_wbdata[r], trace_wbdata);
      end
      // halted rises with the halt's own pulse
      check_bit({name, " halted"}, is_halt, halted);
   endtask

   initial begin
      int          gap;
      int          first_row;
      logic [15:0] hi_a;
      logic [15:0] lo_a;
      logic [15:0] lo_c;
      clk       = 1'b0;
      reset     = 1'b1;
      start     = 1'b0;
      load_we   = 1'b0;
      load_addr = '0;
      load_data = '0;
      void'($urandom(32'h60b2_0bb3));
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      hi_a = 16'($urandom);
      lo_a = 16'($urandom);
      lo_c = 16'($urandom);

      // Constants, register ops, r0 handling, undefined opcode
      begin_program();
      add_row("movhi r1", i_form(tile_pkg::op_movhi, 5'd1, 5'd0, hi_a));
      add_row("addi r3", i_form(tile_pkg::op_addi, 5'd3, 5'd1, lo_a));
      add_row("addi r5 -1", i_form(tile_pkg::op_addi, 5'd5, 5'd0, 16'hffff));
      add_row("add wrap", r_form(tile_pkg::op_add, 5'd4, 5'd5, 5'd5));
      add_row("sub wrap", r_form(tile_pkg::op_sub, 5'd6, 5'd0, 5'd5));
      add_row("and", r_form(tile_pkg::op_and, 5'd7, 5'd3, 5'd5));
      add_row("or", r_form(tile_pkg::op_or, 5'd8, 5'd3, 5'd4));
      add_row("xor", r_form(tile_pkg::op_xor, 5'd9, 5'd3, 5'd5));
      // 36 checks that only rb[4:0] sets the shift
      add_row("addi r10 36", i_form(tile_pkg::op_addi, 5'd10, 5'd0, 16'h0024));
      add_row("sll", r_form(tile_pkg::op_sll, 5'd11, 5'd3, 5'd10));
      add_row("add to r0", r_form(tile_pkg::op_add, 5'd0, 5'd3, 5'd3));
      add_row("read r0", r_form(tile_pkg::op_add, 5'd12, 5'd0, 5'd3));
      add_row("undefined op", 32'h8000_0000);
      add_row("halt 1", i_form(tile_pkg::op_halt, 5'd0, 5'd0, 16'h0000));

      // Branches, words 2 and 3 skipped and never loaded
      begin_program();
      add_row("addi r13 2", i_form(tile_pkg::op_addi, 5'd13, 5'd0, 16'h0002));
      add_row("bnz fwd", i_form(tile_pkg::op_bnz, 5'd0, 5'd13, 16'h0003));
      add_row("dec r13 a", i_form(tile_pkg::op_addi, 5'd13, 5'd13, 16'hffff));
      add_row("bnz back", i_form(tile_pkg::op_bnz, 5'd0, 5'd13, 16'hffff));
      add_row("dec r13 b", i_form(tile_pkg::op_addi, 5'd13, 5'd13, 16'hffff));
      add_row("bnz not taken", i_form(tile_pkg::op_bnz, 5'd0, 5'd13, 16'hffff));
      add_row("bnz r0", i_form(tile_pkg::op_bnz, 5'd0, 5'd0, 16'h0005));
      add_row("halt 2", i_form(tile_pkg::op_halt, 5'd0, 5'd0, 16'h0000));

      // Rerun after halt, earlier registers still live
      begin_program();
      add_row("reuse r3 r12", r_form(tile_pkg::op_add, 5'd14, 5'd3, 5'd12));
      add_row("addi r3 again", i_form(tile_pkg::op_addi, 5'd3, 5'd3, lo_c));
      add_row("halt 3", i_form(tile_pkg::op_halt, 5'd0, 5'd0, 16'h0000));

      // Retirement bound plus reset, loads and start pulses
      limit = 4 * (row_name.size() + n_progs) + 8 + row_name.size() + 2 * n_progs;

      repeat (8) @(negedge clk);
      reset = 1'b0;
      check_bit("reset trace_valid", 1'b0, trace_valid);
      check_bit("reset halted", 1'b0, halted);

      for (int p = 0; p < n_progs; p++) begin
         for (int r = 0; r < row_name.size(); r++) begin
            if (row_prog[r] == p) begin
               load_word(row_pc[r], row_insn[r]);
            end
         end
         @(negedge clk);
         load_we   = 1'b0;
         start     = 1'b1;
         first_row = 1;
         for (int r = 0; r < row_name.size(); r++) begin
            if (row_prog[r] == p) begin
               wait_pulse(gap);
               check_row(r, first_row ? 4 : 3, gap);
               first_row = 0;
            end
         end
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* src.f */
design/tile_pkg.sv
design/insn_decode.sv
design/alu_execute.sv
design/reg_writeback.sv
design/compute_core.sv
design/compute_tile.sv
bench/trace_assert.sv
bench/tb_compute_tile.sv
